// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_ooo_core
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu_unit.sv ====
// Single-cycle integer ALU whose registered result drives the common data bus
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    input  issue_t                 issue_i,
    input  logic [1:0][XLEN-1:0]   src_data_i,   // From PRF read ports
    output cdb_t                   cdb_o
);

    logic [XLEN-1:0]  result;
    logic             cdb_valid_q;
    phy_tag_t         cdb_tag_q;
    rob_idx_t         cdb_rob_q;
    logic [XLEN-1:0]  cdb_val_q;

    // Opcode decode
    always_comb begin
        case (issue_i.op)
            OP_ADD:  result = src_data_i[0] + src_data_i[1];
            OP_SUB:  result = src_data_i[0] - src_data_i[1];
            OP_AND:  result = src_data_i[0] & src_data_i[1];
            OP_OR:   result = src_data_i[0] | src_data_i[1];
            OP_XOR:  result = src_data_i[0] ^ src_data_i[1];
            OP_ADDI: result = src_data_i[0] + issue_i.imm;
            default: result = '0;                         // Unused encodings
        endcase
    end

    // Broadcast strobe, one cycle per issue
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) cdb_valid_q <= 1'b0;
        else          cdb_valid_q <= issue_valid_i;
    end

    always_ff @(posedge clk_i) begin
        cdb_tag_q <= issue_i.dst_tag;
        cdb_rob_q <= issue_i.rob_idx;
        cdb_val_q <= result;
    end

    assign cdb_o = '{valid: cdb_valid_q, tag: cdb_tag_q, rob_idx: cdb_rob_q, value: cdb_val_q};

endmodule

// ==== ooo_core.sv ====
// Top of the out-of-order core from dispatch port to in-order retire port
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             dp_valid_i,
    input  dp_inst_t         dp_inst_i,
    output logic             dp_ready_o,
    output logic             retire_valid_o,
    output arch_idx_t        retire_rd_o,
    output logic [XLEN-1:0]  retire_value_o
);

    logic                  dp_fire;
    logic                  fl_empty;
    logic                  rob_full;
    logic                  rs_full;
    rename_t               rename;
    rob_idx_t              rob_tail;
    logic [1:0]            src_ready;
    logic                  issue_valid;
    issue_t                issue;
    logic [1:0][XLEN-1:0]  src_data;
    cdb_t                  cdb;
    retire_t               retire;

    // --------------------------------------------------
    // Dispatch control
    // --------------------------------------------------
    assign dp_ready_o = !rob_full && !rs_full && !fl_empty;   // All three have room
    assign dp_fire    = dp_valid_i && dp_ready_o;

    rename_unit u_rename (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dp_fire_i  (dp_fire),
        .dp_inst_i  (dp_inst_i),
        .rename_o   (rename),
        .fl_empty_o (fl_empty),
        .retire_i   (retire)
    );

    reorder_buffer u_rob (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dp_fire_i  (dp_fire),
        .dp_inst_i  (dp_inst_i),
        .rename_i   (rename),
        .rob_tail_o (rob_tail),
        .rob_full_o (rob_full),
        .cdb_i      (cdb),
        .retire_o   (retire)
    );

    reservation_station u_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dp_fire_i     (dp_fire),
        .dp_inst_i     (dp_inst_i),
        .rename_i      (rename),
        .rob_idx_i     (rob_tail),
        .src_ready_i   (src_ready),
        .cdb_i         (cdb),
        .rs_full_o     (rs_full),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    phys_regfile u_prf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (dp_fire),
        .alloc_tag_i (rename.new_tag),
        .chk_tag_i   ({rename.src2_tag, rename.src1_tag}),
        .chk_ready_o (src_ready),
        .rd_tag_i    ({issue.src2_tag, issue.src1_tag}),
        .rd_data_o   (src_data),
        .cdb_i       (cdb)
    );

    alu_unit u_alu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .src_data_i    (src_data),
        .cdb_o         (cdb)
    );

    // Retire port
    assign retire_valid_o = retire.valid;
    assign retire_rd_o    = retire.rd;
    assign retire_value_o = retire.value;

endmodule

// ==== ooo_pkg.sv ====
// Shared widths, sizes, opcode encoding and inter-unit structs of the out-of-order core
package ooo_pkg;

    // Sizes
    localparam int XLEN          = 16;
    localparam int ARCH_REG_NUM  = 8;
    localparam int PHY_REG_NUM   = 32;
    localparam int ROB_ENTRY_NUM = 8;
    localparam int RS_ENTRY_NUM  = 4;

    // Derived widths
    localparam int ARCH_IDX_W    = $clog2(ARCH_REG_NUM);
    localparam int PHY_TAG_W     = $clog2(PHY_REG_NUM);
    localparam int ROB_IDX_W     = $clog2(ROB_ENTRY_NUM);
    localparam int RS_IDX_W      = $clog2(RS_ENTRY_NUM);
    localparam int FL_INIT_NUM   = PHY_REG_NUM - ARCH_REG_NUM;   // Tags free after reset

    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [PHY_TAG_W-1:0]  phy_tag_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5     // rs1 + imm, rs2 ignored
    } opcode_e;

    // --------------------------------------------------
    // Structs crossing unit boundaries
    // --------------------------------------------------
    typedef struct packed {
        opcode_e          op;
        arch_idx_t        rd;
        arch_idx_t        rs1;
        arch_idx_t        rs2;
        logic [XLEN-1:0]  imm;
    } dp_inst_t;

    typedef struct packed {
        phy_tag_t  new_tag;    // Freshly allocated for rd
        phy_tag_t  prev_tag;   // Old mapping of rd, freed at retire
        phy_tag_t  src1_tag;
        phy_tag_t  src2_tag;
    } rename_t;

    typedef struct packed {
        opcode_e          op;
        phy_tag_t         src1_tag;
        phy_tag_t         src2_tag;
        logic [XLEN-1:0]  imm;
        phy_tag_t         dst_tag;
        rob_idx_t         rob_idx;
    } issue_t;

    typedef struct packed {
        logic             valid;
        phy_tag_t         tag;
        rob_idx_t         rob_idx;
        logic [XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        arch_idx_t        rd;
        phy_tag_t         prev_tag;
        logic [XLEN-1:0]  value;
    } retire_t;

endpackage

// ==== phys_regfile.sv ====
// Physical register file with per-tag ready bits, CDB write port and issue read ports
`timescale 1ns/1ps

module phys_regfile import ooo_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   alloc_i,        // Dispatch grabs a new tag
    input  phy_tag_t               alloc_tag_i,
    input  phy_tag_t [1:0]         chk_tag_i,      // Dispatch source lookups
    output logic [1:0]             chk_ready_o,
    input  phy_tag_t [1:0]         rd_tag_i,       // Issue operand reads
    output logic [1:0][XLEN-1:0]   rd_data_o,
    input  cdb_t                   cdb_i
);

    logic [XLEN-1:0]         prf_val_q [PHY_REG_NUM];
    logic [PHY_REG_NUM-1:0]  prf_rdy_q;

    // Ready bits
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prf_rdy_q <= '1;                            // Free tags get cleared on allocation
        end else begin
            if (alloc_i)     prf_rdy_q[alloc_tag_i] <= 1'b0;
            if (cdb_i.valid) prf_rdy_q[cdb_i.tag]   <= 1'b1;   // Never the tag being allocated
        end
    end

    // Values; only the initially mapped registers start at zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                prf_val_q[i] <= '0;
            end
        end else if (cdb_i.valid) begin
            prf_val_q[cdb_i.tag] <= cdb_i.value;
        end
    end

    // --------------------------------------------------
    // Combinational lookups
    // --------------------------------------------------
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            chk_ready_o[p] = prf_rdy_q[chk_tag_i[p]];
            rd_data_o[p]   = prf_val_q[rd_tag_i[p]];
        end
    end

endmodule

// ==== rename_unit.sv ====
// Rename stage with speculative map table and circular free list of physical tags
`timescale 1ns/1ps

module rename_unit import ooo_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      dp_fire_i,     // Instruction accepted this cycle
    input  dp_inst_t  dp_inst_i,
    output rename_t   rename_o,
    output logic      fl_empty_o,
    input  retire_t   retire_i       // Returns prev_tag to the free list
);

    phy_tag_t               map_q [ARCH_REG_NUM];   // Arch reg -> current phys tag
    phy_tag_t               fl_q  [PHY_REG_NUM];    // Free tag ring
    logic [PHY_TAG_W-1:0]   fl_head_q;              // Next tag to hand out
    logic [PHY_TAG_W-1:0]   fl_tail_q;              // Next slot for a recycled tag
    logic [PHY_TAG_W:0]     fl_cnt_q;

    // --------------------------------------------------
    // Lookup, purely combinational
    // --------------------------------------------------
    // Sources read the map before this cycle's update, so rd == rs1 is safe
    assign rename_o.new_tag  = fl_q[fl_head_q];
    assign rename_o.prev_tag = map_q[dp_inst_i.rd];
    assign rename_o.src1_tag = map_q[dp_inst_i.rs1];
    assign rename_o.src2_tag = map_q[dp_inst_i.rs2];

    assign fl_empty_o = (fl_cnt_q == '0);

    // --------------------------------------------------
    // Allocate and recycle
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                map_q[i] <= phy_tag_t'(i);                  // Identity mapping
            end
            for (int i = 0; i < FL_INIT_NUM; i++) begin
                fl_q[i] <= phy_tag_t'(i + ARCH_REG_NUM);    // Tags 8..31
            end
            fl_head_q <= '0;
            fl_tail_q <= PHY_TAG_W'(FL_INIT_NUM);
            fl_cnt_q  <= (PHY_TAG_W + 1)'(FL_INIT_NUM);
        end else begin
            if (dp_fire_i) begin
                map_q[dp_inst_i.rd] <= fl_q[fl_head_q];
                fl_head_q           <= fl_head_q + 1'b1;
            end
            if (retire_i.valid) begin
                fl_q[fl_tail_q] <= retire_i.prev_tag;       // Old copy of rd is dead now
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            // Pop and push together leave the count alone
            case ({dp_fire_i, retire_i.valid})
                2'b10:   fl_cnt_q <= fl_cnt_q - 1'b1;
                2'b01:   fl_cnt_q <= fl_cnt_q + 1'b1;
                default: fl_cnt_q <= fl_cnt_q;
            endcase
        end
    end

endmodule

// ==== reorder_buffer.sv ====
// Reorder buffer keeping dispatch order, collecting CDB results and retiring in order
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      dp_fire_i,
    input  dp_inst_t  dp_inst_i,
    input  rename_t   rename_i,
    output rob_idx_t  rob_tail_o,    // Slot the next dispatch lands in
    output logic      rob_full_o,
    input  cdb_t      cdb_i,
    output retire_t   retire_o
);

    // Entry storage, no reset
    logic                rob_done_q  [ROB_ENTRY_NUM];
    arch_idx_t           rob_rd_q    [ROB_ENTRY_NUM];
    phy_tag_t            rob_prev_q  [ROB_ENTRY_NUM];
    logic [XLEN-1:0]     rob_val_q   [ROB_ENTRY_NUM];

    rob_idx_t            head_q;
    rob_idx_t            tail_q;
    logic [ROB_IDX_W:0]  cnt_q;

    logic                rt_valid_q;
    arch_idx_t           rt_rd_q;
    phy_tag_t            rt_prev_q;
    logic [XLEN-1:0]     rt_val_q;

    logic                head_rt;        // Head is complete and leaves this cycle

    assign head_rt    = (cnt_q != '0) && rob_done_q[head_q];
    assign rob_tail_o = tail_q;
    assign rob_full_o = (cnt_q == (ROB_IDX_W + 1)'(ROB_ENTRY_NUM));

    // --------------------------------------------------
    // Pointers and retire strobe
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            cnt_q      <= '0;
            rt_valid_q <= 1'b0;
        end else begin
            rt_valid_q <= head_rt;
            if (dp_fire_i) tail_q <= tail_q + 1'b1;
            if (head_rt)   head_q <= head_q + 1'b1;
            case ({dp_fire_i, head_rt})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Entry contents and retire payload
    always_ff @(posedge clk_i) begin
        if (dp_fire_i) begin
            rob_done_q[tail_q] <= 1'b0;
            rob_rd_q[tail_q]   <= dp_inst_i.rd;
            rob_prev_q[tail_q] <= rename_i.prev_tag;
        end
        if (cdb_i.valid) begin
            rob_done_q[cdb_i.rob_idx] <= 1'b1;        // Never the tail slot, it is in flight
            rob_val_q[cdb_i.rob_idx]  <= cdb_i.value;
        end
        rt_rd_q   <= rob_rd_q[head_q];
        rt_prev_q <= rob_prev_q[head_q];
        rt_val_q  <= rob_val_q[head_q];
    end

    assign retire_o = '{valid: rt_valid_q, rd: rt_rd_q, prev_tag: rt_prev_q, value: rt_val_q};

endmodule

// ==== reservation_station.sv ====
// Reservation station with CDB wake-up and oldest-slot-agnostic lowest-index issue select
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        dp_fire_i,
    input  dp_inst_t    dp_inst_i,
    input  rename_t     rename_i,
    input  rob_idx_t    rob_idx_i,
    input  logic [1:0]  src_ready_i,   // PRF ready bits of src1/src2
    input  cdb_t        cdb_i,
    output logic        rs_full_o,
    output logic        issue_valid_o,
    output issue_t      issue_o
);

    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    logic [RS_ENTRY_NUM-1:0]  valid_q;
    issue_t                   ent_q  [RS_ENTRY_NUM];   // Payload per slot
    logic                     rdy1_q [RS_ENTRY_NUM];
    logic                     rdy2_q [RS_ENTRY_NUM];

    rs_idx_t                  ins_idx;   // Lowest free slot
    rs_idx_t                  sel_idx;   // Lowest ready slot
    logic                     new_rdy1;
    logic                     new_rdy2;

    assign rs_full_o = &valid_q;

    // --------------------------------------------------
    // Slot pick and issue select
    // --------------------------------------------------
    always_comb begin
        ins_idx       = '0;
        sel_idx       = '0;
        issue_valid_o = 1'b0;
        // Walk downwards so the lowest index wins
        for (int i = RS_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                ins_idx = rs_idx_t'(i);
            end
            if (valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                sel_idx       = rs_idx_t'(i);
                issue_valid_o = 1'b1;
            end
        end
    end

    assign issue_o = ent_q[sel_idx];

    // Same-cycle CDB catch for the entry being inserted
    assign new_rdy1 = src_ready_i[0]
                    || (cdb_i.valid && (cdb_i.tag == rename_i.src1_tag));
    assign new_rdy2 = (dp_inst_i.op == OP_ADDI)            // No second source
                    || src_ready_i[1]
                    || (cdb_i.valid && (cdb_i.tag == rename_i.src2_tag));

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            if (issue_valid_o) valid_q[sel_idx] <= 1'b0;   // Slot frees on issue
            if (dp_fire_i)     valid_q[ins_idx] <= 1'b1;   // Full level keeps these apart
        end
    end

    // Payload and operand wake-up
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_ENTRY_NUM; i++) begin
            if (valid_q[i] && cdb_i.valid) begin
                if (cdb_i.tag == ent_q[i].src1_tag) rdy1_q[i] <= 1'b1;
                if (cdb_i.tag == ent_q[i].src2_tag) rdy2_q[i] <= 1'b1;
            end
        end
        if (dp_fire_i) begin
            ent_q[ins_idx] <= '{op:       dp_inst_i.op,
                                src1_tag: rename_i.src1_tag,
                                src2_tag: rename_i.src2_tag,
                                imm:      dp_inst_i.imm,
                                dst_tag:  rename_i.new_tag,
                                rob_idx:  rob_idx_i};
            rdy1_q[ins_idx] <= new_rdy1;
            rdy2_q[ins_idx] <= new_rdy2;
        end
    end

endmodule

// ==== tb.f ====
ooo_pkg.sv
rename_unit.sv
reorder_buffer.sv
reservation_station.sv
phys_regfile.sv
alu_unit.sv
ooo_core.sv
tb_clkgen.sv
tb_ooo_core.sv

// ==== tb_clkgen.sv ====
// Testbench clock and reset source, 40 ns clock and 16-cycle synchronous reset
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;    // ns
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== tb_ooo_core.sv ====
// Testbench for the out-of-order core with a sequential reference model and retire checks
`timescale 1ns/1ps

module tb_ooo_core import ooo_pkg::*; ();

    localparam int RESET_READS    = 4;
    localparam int CHAIN_LEN      = 8;
    localparam int ORDER_LEN      = 10;
    localparam int RAND_LEN       = 200;
    localparam int BURST_LEN      = 24;
    localparam int TOTAL_INST     = RESET_READS + CHAIN_LEN + ORDER_LEN + RAND_LEN + BURST_LEN;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_INST + 200;
    localparam int DRAIN_CYCLES   = 20 * ROB_ENTRY_NUM;   // At most a full ROB once dispatch stops

    typedef struct packed {
        arch_idx_t        rd;
        logic [XLEN-1:0]  value;
    } exp_t;

    logic             clk;
    logic             rst_n;
    logic             dp_valid;
    dp_inst_t         dp_inst;
    logic             dp_ready;
    logic             retire_valid;
    arch_idx_t        retire_rd;
    logic [XLEN-1:0]  retire_value;

    logic [XLEN-1:0]  model_regs [ARCH_REG_NUM];   // Architectural state in program order
    exp_t             exp_q [$];                    // Expected retire stream
    exp_t             head_exp;
    string            test_name    = "reset_state";
    int               cycle_cnt    = 0;
    int               accepted_cnt = 0;
    int               retired_cnt  = 0;
    bit               in_burst     = 1'b0;
    bit               stall_seen   = 1'b0;
    bit               reset_phase  = 1'b1;          // Reset and idle window checks

    tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    ooo_core u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .dp_valid_i     (dp_valid),
        .dp_inst_i      (dp_inst),
        .dp_ready_o     (dp_ready),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_value_o (retire_value)
    );

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    // --------------------------------------------------
    // Reference model and stimulus helpers
    // --------------------------------------------------
    function automatic logic [XLEN-1:0] model_result(input dp_inst_t inst);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        a = model_regs[inst.rs1];
        b = model_regs[inst.rs2];
        case (inst.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            default: res = a + inst.imm;     // ADDI
        endcase
        return res;
    endfunction

    function automatic dp_inst_t make_inst(input opcode_e op, input int rd, input int rs1,
                                           input int rs2, input logic [XLEN-1:0] imm);
        dp_inst_t inst;
        inst.op  = op;
        inst.rd  = arch_idx_t'(rd);
        inst.rs1 = arch_idx_t'(rs1);
        inst.rs2 = arch_idx_t'(rs2);
        inst.imm = imm;
        return inst;
    endfunction

    // Ready only moves at rising edges, so a high level here means accept at the next one
    task automatic send_inst(input dp_inst_t inst);
        exp_t e;
        @(negedge clk);
        dp_inst  = inst;
        dp_valid = 1'b1;
        while (!dp_ready) begin
            if (in_burst) stall_seen = 1'b1;
            @(negedge clk);
        end
        e.rd               = inst.rd;
        e.value            = model_result(inst);
        model_regs[inst.rd] = e.value;
        exp_q.push_back(e);
        accepted_cnt++;
    endtask

    task automatic go_idle();
        @(negedge clk);
        dp_valid = 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // --------------------------------------------------
    // Checkers
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) abort_run("Timeout, the core stopped retiring");
    end

    // No retire, ready high, through reset and the idle cycles after it
    always @(negedge clk) begin
        if (reset_phase && cycle_cnt >= 1) begin
            assert (!retire_valid && dp_ready)
            else report_mismatch("reset_state valid/ready", 32'h1,
                                 32'({retire_valid, dp_ready}));
        end
    end

    // Retire stream against model queue
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("Retire strobe with no accepted instruction outstanding");
            end else begin
                head_exp = exp_q.pop_front();
                retired_cnt++;
                // rd sits in bits 18:16
                assert (retire_rd == head_exp.rd && retire_value == head_exp.value)
                else report_mismatch($sformatf("%s retire", test_name),
                                     32'(head_exp), 32'({retire_rd, retire_value}));
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(51));
        dp_valid = 1'b0;
        dp_inst  = '0;
        for (int i = 0; i < ARCH_REG_NUM; i++) model_regs[i] = '0;
        @(posedge rst_n);
        repeat (4) @(negedge clk);
        reset_phase = 1'b0;

        // Every register read once before any write to it
        send_inst(make_inst(OP_ADD, 0, 0, 1, 16'h0));
        send_inst(make_inst(OP_ADD, 2, 2, 3, 16'h0));
        send_inst(make_inst(OP_ADD, 4, 4, 5, 16'h0));
        send_inst(make_inst(OP_ADD, 6, 6, 7, 16'h0));
        go_idle();
        wait_drain(DRAIN_CYCLES);

        test_name = "dependent_chain";
        send_inst(make_inst(OP_ADDI, 1, 1, 0, 16'h0005));
        send_inst(make_inst(OP_ADDI, 1, 1, 0, 16'h0100));
        send_inst(make_inst(OP_ADDI, 1, 1, 0, 16'hffff));  // Minus one
        send_inst(make_inst(OP_ADDI, 1, 1, 0, 16'h0020));
        send_inst(make_inst(OP_ADD,  2, 1, 1, 16'h0));
        send_inst(make_inst(OP_SUB,  3, 2, 1, 16'h0));
        send_inst(make_inst(OP_SUB,  4, 0, 3, 16'h0));
        send_inst(make_inst(OP_ADD,  5, 4, 3, 16'h0));
        go_idle();
        wait_drain(DRAIN_CYCLES);

        // Long r6 chain, then work that does not depend on it
        test_name = "program_order";
        send_inst(make_inst(OP_ADDI, 6, 6, 0, 16'h0003));
        send_inst(make_inst(OP_ADDI, 6, 6, 0, 16'h0011));
        send_inst(make_inst(OP_ADDI, 6, 6, 0, 16'h0200));
        send_inst(make_inst(OP_ADDI, 6, 6, 0, 16'h0007));
        send_inst(make_inst(OP_ADD,  7, 6, 6, 16'h0));
        send_inst(make_inst(OP_ADDI, 0, 0, 0, 16'h0055));
        send_inst(make_inst(OP_ADDI, 1, 0, 0, 16'h1234));
        send_inst(make_inst(OP_XOR,  2, 1, 0, 16'h0));
        send_inst(make_inst(OP_OR,   3, 2, 1, 16'h0));
        send_inst(make_inst(OP_AND,  5, 3, 2, 16'h0));
        go_idle();
        wait_drain(DRAIN_CYCLES);

        test_name = "all_opcodes";
        for (int n = 0; n < RAND_LEN; n++) begin
            send_inst(make_inst(opcode_e'($urandom_range(5, 0)), $urandom_range(7, 0),
                                $urandom_range(7, 0), $urandom_range(7, 0),
                                XLEN'($urandom())));
        end
        go_idle();
        wait_drain(DRAIN_CYCLES);

        // One dependent ADDI per two cycles against one dispatch per cycle
        test_name = "back_pressure";
        in_burst  = 1'b1;
        for (int n = 0; n < BURST_LEN; n++) begin
            send_inst(make_inst(OP_ADDI, 4, 4, 0, 16'h0001));
        end
        go_idle();
        in_burst = 1'b0;
        wait_drain(DRAIN_CYCLES);
        repeat (4) @(negedge clk);    // Catch any stray strobe

        if (retired_cnt == accepted_cnt && exp_q.size() == 0 && stall_seen) begin
            $display("*** PASSED ***");
            $finish;
        end else if (retired_cnt != accepted_cnt) begin
            report_mismatch("back_pressure retire count", 32'(accepted_cnt), 32'(retired_cnt));
        end else begin
            abort_run("dp_ready_o never dropped during the dispatch burst");
        end
    end

endmodule
